// File: run_sim.sh
#!/bin/sh
# build and run the FM operator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module fm_operator_tb -o fm_operator_sim \
    && ./obj_dir/fm_operator_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

// File: source/envelope_gen.sv
`timescale 1ns/1ns
`include "fm_operator_settings.svh"

module envelope_gen (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sample_en,
    input  logic                      kon,
    input  fm_operator_pkg::op_regs_t regs,
    output fm_operator_pkg::atten_t   atten
);

    import fm_operator_pkg::*;

    localparam int CNT_W = 15;   // rate counter, rate r uses 15-r low bits

    env_state_t       state;       // ADSR phase
    atten_t           level;       // envelope attenuation, 511 = silent
    logic [CNT_W-1:0] rate_cnt;    // free running, one step per enable
    logic             kon_q;       // kon at previous enable
    env_rate_t        rate;        // rate of the current phase
    logic [CNT_W-1:0] rate_mask;   // low counter bits that must be zero
    logic             rate_act;    // step allowed on this enable
    atten_t           atk_dec;     // attack decrement, level/8 + 1
    atten_t           atk_next;    // level after one attack step
    atten_t           lin_next;    // level after one linear step
    atten_t           sus_target;  // decay end point
    logic [`FM_ATTEN_W:0] tl_sum;  // level plus total level, one spare bit

    always_comb begin
        case (state)
            ENV_ATTACK: rate = regs.ar;
            ENV_DECAY:  rate = regs.dr;
            default:    rate = regs.rr;   // sustain without egt, release
        endcase
    end

    // rate 15 acts every enable, rate 1 every 2^14 enables
    assign rate_mask = (CNT_W'(1) << (4'd15 - rate)) - CNT_W'(1);
    assign rate_act  = (rate != '0) && ((rate_cnt & rate_mask) == '0);

    assign atk_dec  = (level >> 3) + atten_t'(1);
    assign atk_next = (level > atk_dec) ? (level - atk_dec) : '0;  // clamp at 0
    assign lin_next = (level == '1) ? level : (level + atten_t'(1)); // stop at 511

    // sl 15 goes all the way to silence
    assign sus_target = (regs.sl == 4'd15) ? '1 : {1'b0, regs.sl, 4'b0000};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ENV_RELEASE;
            level    <= '1;            // start silent
            rate_cnt <= '0;
            kon_q    <= 1'b0;
        end else if (sample_en) begin
            kon_q    <= kon;
            rate_cnt <= rate_cnt + CNT_W'(1);
            if (kon && !kon_q) begin
                state <= ENV_ATTACK;   // rise from wherever the level is
            end else if (!kon && kon_q) begin
                state <= ENV_RELEASE;  // key-off
            end else begin
                case (state)
                    ENV_ATTACK: begin
                        if (level == '0) begin
                            state <= ENV_DECAY;        // peak reached
                        end else if (rate_act) begin
                            level <= atk_next;
                        end
                    end
                    ENV_DECAY: begin
                        if (level >= sus_target) begin
                            state <= ENV_SUSTAIN;
                        end else if (rate_act) begin
                            level <= lin_next;         // 0.1875 dB per step
                        end
                    end
                    ENV_SUSTAIN: begin
                        if (!regs.egt && rate_act) begin
                            level <= lin_next;         // percussive, keeps falling
                        end
                    end
                    default: begin
                        if (rate_act) begin
                            level <= lin_next;         // release
                        end
                    end
                endcase
            end
        end
    end

    // total level is 0.75 dB, four envelope steps per lsb
    assign tl_sum = {1'b0, level} + {2'b00, regs.tl, 2'b00};
    assign atten  = tl_sum[`FM_ATTEN_W] ? '1 : tl_sum[`FM_ATTEN_W-1:0]; // saturate

endmodule

// File: source/fm_operator.sv
`timescale 1ns/1ns

module fm_operator (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      kon,
    input  fm_operator_pkg::op_regs_t regs,
    output fm_operator_pkg::sample_t  sample
);

    import fm_operator_pkg::*;

    logic   sample_en;  // one clock per sample period
    phase_t phase;      // from phase accumulator
    atten_t atten;      // from envelope

    sample_clk_div u_clk_div (
        .clk       (clk),
        .rst       (rst),
        .sample_en (sample_en)
    );

    phase_accum u_phase (
        .clk       (clk),
        .rst       (rst),
        .sample_en (sample_en),
        .kon       (kon),
        .regs      (regs),
        .phase     (phase)
    );

    envelope_gen u_env (
        .clk       (clk),
        .rst       (rst),
        .sample_en (sample_en),
        .kon       (kon),
        .regs      (regs),
        .atten     (atten)
    );

    // sample appears three clocks after the enable pulse
    wave_shaper u_wave (
        .clk       (clk),
        .rst       (rst),
        .sample_en (sample_en),
        .phase     (phase),
        .atten     (atten),
        .ws        (regs.ws),
        .sample    (sample)
    );

endmodule

// File: source/fm_operator_pkg.sv
`include "fm_operator_settings.svh"

package fm_operator_pkg;

    typedef logic [`FM_FNUM_W-1:0]   fnum_t;      // frequency number
    typedef logic [`FM_BLOCK_W-1:0]  block_t;     // octave shift
    typedef logic [`FM_MULT_W-1:0]   mult_t;      // multiplier code
    typedef logic [`FM_WS_W-1:0]     ws_t;        // waveform select
    typedef logic [`FM_RATE_W-1:0]   env_rate_t;  // envelope rate, 0 = frozen
    typedef logic [`FM_SL_W-1:0]     sus_lvl_t;   // sustain level, 3 dB steps
    typedef logic [`FM_TL_W-1:0]     tl_t;        // total level
    typedef logic [`FM_PHASE_W-1:0]  phase_t;     // phase accumulator
    typedef logic [`FM_ATTEN_W-1:0]  atten_t;     // attenuation
    typedef logic signed [`FM_SAMPLE_W-1:0] sample_t; // signed sample

    // operator register image, held as static levels
    typedef struct packed {
        fnum_t     fnum;   // pitch
        block_t    block;  // octave
        mult_t     mult;   // frequency multiplier
        ws_t       ws;     // waveform
        env_rate_t ar;     // attack rate
        env_rate_t dr;     // decay rate
        sus_lvl_t  sl;     // sustain level
        env_rate_t rr;     // release rate
        tl_t       tl;     // total level
        logic      egt;    // 1 = hold at sustain
    } op_regs_t;

    // ADSR phases
    typedef enum logic [1:0] {
        ENV_ATTACK  = 2'd0,  // exponential rise
        ENV_DECAY   = 2'd1,  // linear fall to sl
        ENV_SUSTAIN = 2'd2,  // hold or fall at rr
        ENV_RELEASE = 2'd3   // linear fall after key-off
    } env_state_t;

endpackage

// File: source/fm_operator_settings.svh
`ifndef FM_OPERATOR_SETTINGS_SVH
`define FM_OPERATOR_SETTINGS_SVH

// sample rate pacing
`define FM_CLK_DIV 32          // system clocks per sample enable

// datapath widths
`define FM_PHASE_W 19          // phase accumulator, one turn = 2^19
`define FM_ATTEN_W 9           // attenuation, 0.1875 dB per lsb
`define FM_SAMPLE_W 13         // signed operator output

// register field widths
`define FM_FNUM_W 10           // frequency number
`define FM_BLOCK_W 3           // octave
`define FM_MULT_W 4            // multiplier code
`define FM_WS_W 2              // waveform select
`define FM_RATE_W 4            // attack, decay, release rates
`define FM_SL_W 4              // sustain level
`define FM_TL_W 6              // total level, 0.75 dB per lsb

`endif

// File: source/phase_accum.sv
`timescale 1ns/1ns
`include "fm_operator_settings.svh"

module phase_accum (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sample_en,
    input  logic                      kon,
    input  fm_operator_pkg::op_regs_t regs,
    output fm_operator_pkg::phase_t   phase
);

    import fm_operator_pkg::*;

    localparam int MULT_X2_W = 5;                          // doubled factor, max 30
    localparam int PROD_W    = $bits(fnum_t) + MULT_X2_W;  // fnum * factor * 2
    localparam int SHIFT_W   = PROD_W + 7;                 // room for block 7

    logic [MULT_X2_W-1:0] mult_x2;   // twice the multiplier factor
    logic [PROD_W-1:0]    base_prod; // fnum * mult_x2
    logic [SHIFT_W-1:0]   shifted;   // after octave shift
    phase_t               inc;       // step per sample
    logic                 kon_q;     // kon seen at last enable

    // code 0 is one half, 11/13/15 repeat their neighbour
    always_comb begin
        case (regs.mult)
            4'd0:    mult_x2 = 5'd1;
            4'd1:    mult_x2 = 5'd2;
            4'd2:    mult_x2 = 5'd4;
            4'd3:    mult_x2 = 5'd6;
            4'd4:    mult_x2 = 5'd8;
            4'd5:    mult_x2 = 5'd10;
            4'd6:    mult_x2 = 5'd12;
            4'd7:    mult_x2 = 5'd14;
            4'd8:    mult_x2 = 5'd16;
            4'd9:    mult_x2 = 5'd18;
            4'd10:   mult_x2 = 5'd20;
            4'd11:   mult_x2 = 5'd20;
            4'd12:   mult_x2 = 5'd24;
            4'd13:   mult_x2 = 5'd24;
            default: mult_x2 = 5'd30;   // 14 and 15
        endcase
    end

    assign base_prod = PROD_W'(regs.fnum) * PROD_W'(mult_x2);
    assign shifted   = SHIFT_W'(base_prod) << regs.block;
    assign inc       = shifted[`FM_PHASE_W+1:2];  // undo doubling, then halve

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
            kon_q <= 1'b0;
        end else if (sample_en) begin
            kon_q <= kon;
            if (kon && !kon_q) begin
                phase <= '0;            // key-on restarts the wave
            end else begin
                phase <= phase + inc;   // wraps mod 2^19
            end
        end
    end

endmodule

// File: source/sample_clk_div.sv
`timescale 1ns/1ns
`include "fm_operator_settings.svh"

module sample_clk_div (
    input  logic clk,
    input  logic rst,
    output logic sample_en
);

    localparam int CNT_W = $clog2(`FM_CLK_DIV);  // counter width

    logic [CNT_W-1:0] cnt;  // position inside sample period
    logic             wrap; // last clock of the period

    assign wrap = (cnt == CNT_W'(`FM_CLK_DIV - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt       <= '0;
            sample_en <= 1'b0;
        end else begin
            sample_en <= wrap;             // one clock wide pulse
            if (wrap) begin
                cnt <= '0;                 // start next period
            end else begin
                cnt <= cnt + CNT_W'(1);
            end
        end
    end

    // first pulse lands FM_CLK_DIV clocks after reset goes low
    // since the enable is registered off the wrap

endmodule

// File: source/wave_shaper.sv
`timescale 1ns/1ns
`include "fm_operator_settings.svh"

module wave_shaper (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     sample_en,
    input  fm_operator_pkg::phase_t  phase,
    input  fm_operator_pkg::atten_t  atten,
    input  fm_operator_pkg::ws_t     ws,
    output fm_operator_pkg::sample_t sample
);

    import fm_operator_pkg::*;

    localparam int TAB_W = 12;   // table entry width
    localparam int SUM_W = 13;   // log domain sum, shift in top 5 bits
    localparam int MAG_W = `FM_SAMPLE_W - 1;
    localparam real PI   = 3.14159265358979;

    logic [TAB_W-1:0] logsin_rom [256];  // -log2(sin) * 256, quarter wave
    logic [TAB_W-1:0] exp_rom [256];     // 4095 * 2^(-i/256)

    // tables built at elaboration, sampled at bin centres
    for (genvar i = 0; i < 256; i++) begin : g_rom
        localparam real ANGLE  = (real'(i) + 0.5) * PI / 512.0;
        localparam real LOGSIN = -$ln($sin(ANGLE)) / $ln(2.0) * 256.0;
        localparam real EXPV   = 4095.0 * (2.0 ** (-real'(i) / 256.0));
        assign logsin_rom[i] = TAB_W'($rtoi(LOGSIN + 0.5));
        assign exp_rom[i]    = TAB_W'($rtoi(EXPV + 0.5));
    end

    logic [9:0]       top;        // upper phase bits, quadrant + index
    logic [7:0]       quarter;    // index into quarter wave
    logic             sign;       // negative half
    logic             mute;       // forced silence
    logic [SUM_W-1:0] log_sum;    // sine attenuation plus envelope
    logic             en_d1;      // stage 1 strobe
    logic             en_d2;      // stage 2 strobe
    logic [SUM_W-1:0] s1_sum;
    logic             s1_sign;
    logic             s1_mute;
    logic [MAG_W-1:0] mag;        // linear magnitude

    assign top = phase[`FM_PHASE_W-1 -: 10];

    always_comb begin
        quarter = top[8] ? ~top[7:0] : top[7:0];  // mirror falling quarters
        sign    = 1'b0;
        mute    = 1'b0;
        case (ws)
            2'd0: sign = top[9];                  // full sine
            2'd1: mute = top[9];                  // half sine
            2'd2: sign = 1'b0;                    // absolute sine
            default: begin
                mute    = top[8];                 // rising quarters only
                quarter = top[7:0];
            end
        endcase
        if (atten == '1) begin
            mute = 1'b1;                          // envelope fully off
        end
    end

    // one envelope lsb of 0.1875 dB is eight table units of 6/256 dB
    assign log_sum = SUM_W'(logsin_rom[quarter]) + SUM_W'({atten, 3'b000});

    assign mag = MAG_W'(exp_rom[s1_sum[7:0]] >> s1_sum[SUM_W-1:8]);

    always_ff @(posedge clk) begin
        if (rst) begin
            en_d1  <= 1'b0;
            en_d2  <= 1'b0;
            sample <= '0;
        end else begin
            en_d1 <= sample_en;    // phase and atten settled here
            en_d2 <= en_d1;
            if (en_d2) begin
                if (s1_mute) begin
                    sample <= '0;
                end else if (s1_sign) begin
                    sample <= -$signed({1'b0, mag});
                end else begin
                    sample <= $signed({1'b0, mag});
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_d1) begin
            s1_sum  <= log_sum;
            s1_sign <= sign;
            s1_mute <= mute;
        end
    end

endmodule

// File: src.f
+incdir+source
source/fm_operator_pkg.sv
source/sample_clk_div.sv
source/phase_accum.sv
source/envelope_gen.sv
source/wave_shaper.sv
source/fm_operator.sv
tb/fm_operator_tb.sv

// File: tb/fm_operator_tb.sv
`timescale 1ns/1ns
`include "fm_operator_settings.svh"

module fm_operator_tb;

    import fm_operator_pkg::*;

    localparam int FULL_SCALE = 4095;  // magnitude at zero attenuation
    localparam int N_QUIET    = 64;    // silence after reset
    localparam int N_ATTACK   = 600;   // time allowed to reach the peak
    localparam int N_WAVE     = 260;   // one tone period plus guard
    localparam int N_LEVEL    = 260;   // per total level step, incl 2 settling
    localparam int N_RELEASE  = 520;   // 511 release steps plus margin
    localparam int N_TAIL     = 16;    // extra silent periods
    localparam int N_FROZEN   = 256;   // ar 0 keeps it silent
    localparam int N_SETTLE   = 64;
    localparam int N_PITCH    = 1024;  // samples per pitch run
    localparam int PITCH_RUNS = 4;
    localparam int N_RESTART  = 64;
    localparam int TOTAL_SAMPLES = N_QUIET + N_ATTACK + 4 * (N_WAVE + 1) + 3 * N_LEVEL
        + N_RELEASE + N_TAIL + N_FROZEN + N_SETTLE + PITCH_RUNS * (N_PITCH + 2)
        + N_RELEASE + N_RESTART;
    localparam longint WATCHDOG_NS = longint'(TOTAL_SAMPLES) * `FM_CLK_DIV * 10 + 50000;

    // doubled multiplier factors, 1/2 1 2 .. 10 10 12 12 15 15
    localparam int MULT_X2 [16] = '{1, 2, 4, 6, 8, 10, 12, 14, 16, 18, 20, 20, 24, 24, 30, 30};

    logic     clk;
    logic     rst;
    logic     kon;
    op_regs_t regs;
    sample_t  sample;
    int       errors;   // failed checks
    integer   seed;     // $random state

    fm_operator uut (
        .clk    (clk),
        .rst    (rst),
        .kon    (kon),
        .regs   (regs),
        .sample (sample)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;   // 10 ns period

    task automatic check_true(input bit ok, input string what);
        assert (ok) else begin
            $display("[ERROR] %0t %s", $time, what);
            errors++;
        end
    endtask

    // one sample period later, read at a falling edge
    task automatic next_sample(output sample_t s);
        repeat (`FM_CLK_DIV) @(negedge clk);
        s = sample;
    endtask

    function automatic int magnitude(input sample_t s);
        int v;
        v = int'(s);
        return (v < 0) ? -v : v;
    endfunction

    // fnum * factor << block, halved
    function automatic int phase_step(input int fnum, input int blk, input int mult);
        return ((fnum * MULT_X2[mult]) << blk) / 4;
    endfunction

    function automatic real expected_peak(input int tl);
        return real'(FULL_SCALE) * (2.0 ** (-real'(tl) * 4.0 / 32.0));
    endfunction

    // kon low for exactly one enable, level stays where it was
    task automatic retrigger();
        kon = 1'b0;
        repeat (`FM_CLK_DIV) @(negedge clk);
        kon = 1'b1;
    endtask

    task automatic reset_silence();
        sample_t s;
        for (int i = 0; i < N_QUIET; i++) begin
            next_sample(s);
            check_true(s == 0, $sformatf("sample %0d after reset is %0d, not 0", i, s));
        end
    endtask

    task automatic play_wave(input int ws_sel, input int quarter_len);
        sample_t s;
        int      m;
        int      pos_in_q;
        int      quadrant;
        bit      seen_pos;
        bit      seen_neg;
        seen_pos = 1'b0;
        seen_neg = 1'b0;
        regs.ws  = ws_t'(ws_sel);
        retrigger();                            // phase back to zero
        for (int j = 1; j <= N_WAVE; j++) begin
            next_sample(s);
            m        = j - 1;                   // enables since restart, maybe one less
            pos_in_q = m % quarter_len;
            quadrant = (m / quarter_len) % 4;
            if (s > 0) seen_pos = 1'b1;
            if (s < 0) seen_neg = 1'b1;
            if (ws_sel == 1 || ws_sel == 2) begin
                check_true(s >= 0, $sformatf("ws %0d sample %0d is negative (%0d)",
                                             ws_sel, j, s));
                if (quadrant >= 2 && pos_in_q >= 2 && pos_in_q < quarter_len - 2) begin
                    if (ws_sel == 1) begin
                        check_true(s == 0, $sformatf("ws 1 sample %0d in the negative half is %0d",
                                                     j, s));
                    end else begin
                        check_true(s > 0, $sformatf("ws 2 sample %0d in the negative half is %0d",
                                                    j, s));
                    end
                end
            end
            if (ws_sel == 3 && pos_in_q >= 2 && pos_in_q < quarter_len - 2) begin
                if ((quadrant % 2) == 1) begin
                    check_true(s == 0, $sformatf("ws 3 quadrant %0d sample %0d is %0d, not 0",
                                                 quadrant, j, s));
                end else begin
                    check_true(s > 0, $sformatf("ws 3 quadrant %0d sample %0d is %0d, not > 0",
                                                quadrant, j, s));
                end
            end
        end
        if (ws_sel == 0) begin
            check_true(seen_pos && seen_neg, "ws 0 did not show both signs over one period");
        end
    endtask

    task automatic attack_and_waves();
        sample_t s;
        int      peak;
        int      quarter_len;
        regs.fnum  = 10'd512;                   // 256 samples per tone period
        regs.block = 3'd3;
        regs.mult  = 4'd1;
        regs.ws    = 2'd0;
        regs.ar    = 4'd15;
        regs.dr    = 4'd0;
        regs.sl    = 4'd0;
        regs.rr    = 4'd15;
        regs.tl    = 6'd0;
        regs.egt   = 1'b1;                      // hold at sustain
        kon        = 1'b1;
        peak       = 0;
        for (int i = 0; i < N_ATTACK; i++) begin
            next_sample(s);
            if (magnitude(s) > peak) peak = magnitude(s);
        end
        check_true(real'(peak) >= 0.98 * FULL_SCALE && peak <= FULL_SCALE,
                   $sformatf("attack peak %0d, expected about %0d", peak, FULL_SCALE));
        quarter_len = (1 << (`FM_PHASE_W - 2)) / phase_step(512, 3, 1);
        for (int w = 0; w < 4; w++) begin
            play_wave(w, quarter_len);
        end
    endtask

    task automatic level_scaling();
        sample_t s;
        int      peak;
        int      tl_val;
        real     limit;
        regs.ws = 2'd0;
        for (int k = 0; k < 3; k++) begin
            tl_val  = 8 << k;                   // 8, 16, 32
            regs.tl = tl_t'(tl_val);
            next_sample(s);                     // new tl reaches the output
            next_sample(s);
            peak = 0;
            for (int i = 0; i < N_LEVEL - 2; i++) begin
                next_sample(s);
                if (magnitude(s) > peak) peak = magnitude(s);
            end
            limit = expected_peak(tl_val);
            check_true(real'(peak) >= 0.98 * limit && real'(peak) <= limit,
                       $sformatf("tl %0d peak %0d, expected %f", tl_val, peak, limit));
        end
    endtask

    task automatic release_and_frozen_attack();
        sample_t s;
        regs.tl = 6'd0;
        regs.rr = 4'd15;
        kon     = 1'b0;                         // key-off, one step per sample
        for (int i = 0; i < N_RELEASE; i++) begin
            next_sample(s);
        end
        for (int i = 0; i < N_TAIL; i++) begin
            next_sample(s);
            check_true(s == 0, $sformatf("release tail sample %0d is %0d, not 0", i, s));
        end
        regs.ar = 4'd0;                         // attack never acts
        kon     = 1'b1;
        for (int i = 0; i < N_FROZEN; i++) begin
            next_sample(s);
            check_true(s == 0, $sformatf("ar 0 sample %0d is %0d, not 0", i, s));
        end
    endtask

    task automatic pitch_tracking();
        sample_t s;
        int      fnum;
        int      blk;
        int      flips;
        int      last_sign;
        int      sgn;
        real     expect_flips;
        regs.ar   = 4'd15;                      // frozen attack now runs to full level
        regs.mult = 4'd1;
        regs.ws   = 2'd0;
        for (int i = 0; i < N_SETTLE; i++) begin
            next_sample(s);
        end
        for (int r = 0; r < PITCH_RUNS; r++) begin
            fnum       = ($random(seed) & 32'h3ff) | 32'h40;  // at least 64
            blk        = $unsigned($random(seed)) % 6;
            regs.fnum  = fnum_t'(fnum);
            regs.block = block_t'(blk);
            regs.tl    = tl_t'($random(seed) & 31);
            next_sample(s);                     // skip the pitch change
            next_sample(s);
            flips     = 0;
            last_sign = 0;
            for (int i = 0; i < N_PITCH; i++) begin
                next_sample(s);
                if (s != 0) begin
                    sgn = (s > 0) ? 1 : -1;
                    if (last_sign != 0 && sgn != last_sign) flips++;
                    last_sign = sgn;
                end
            end
            expect_flips = 2.0 * real'(N_PITCH) * real'(phase_step(fnum, blk, 1))
                           / (2.0 ** `FM_PHASE_W);
            check_true(real'(flips) >= expect_flips - 2.0 && real'(flips) <= expect_flips + 2.0,
                       $sformatf("fnum %0d block %0d: %0d sign changes, expected %f",
                                 fnum, blk, flips, expect_flips));
        end
    endtask

    task automatic restart_phase();
        sample_t s;
        int      found;
        regs.fnum  = 10'd512;
        regs.block = 3'd3;
        regs.mult  = 4'd1;
        regs.ws    = 2'd0;
        regs.tl    = 6'd0;
        regs.rr    = 4'd15;
        regs.ar    = 4'd15;
        kon        = 1'b0;
        for (int i = 0; i < N_RELEASE; i++) begin
            next_sample(s);
        end
        check_true(s == 0, $sformatf("not silent before retrigger, sample %0d", s));
        kon   = 1'b1;                           // phase restarts from zero
        found = 0;
        for (int i = 0; i < N_RESTART; i++) begin
            next_sample(s);
            if (s != 0 && found < 8) begin
                check_true(s > 0, $sformatf("sample %0d after key-on is %0d, not > 0", i, s));
                found++;
            end
        end
        check_true(found == 8, "no sound came out after the key-on retrigger");
    endtask

    initial begin
        errors = 0;
        seed   = 32'hb4f1_6b4d;
        rst    = 1'b1;
        kon    = 1'b0;
        regs   = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        reset_silence();
        attack_and_waves();
        level_scaling();
        release_and_frozen_attack();
        pitch_tracking();
        restart_phase();
        $display("all tests done, errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // stops a stuck run
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, tests did not finish, errors so far: %0d", errors);
        $display("test failed");
        $finish;
    end

endmodule
